/* Bender.yml */
package:
  name: video_scaler

sources:
  - common/video_pkg.sv
  - common/scan_timing_pkg.sv
  - common/line_bus_if.sv
  - upscaler/line_writer.sv
  - upscaler/line_buffer.sv
  - upscaler/line_reader.sv
  - upscaler/upscaler.sv
  - logic/vga_sync_gen.sv
  - logic/video_scaler_top.sv
  - target: test
    files:
      - verification/video_scaler_tb.sv

/* common/line_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////
// Write side of the ring
//////////////////////////////

interface line_write_if import video_pkg::*; #(
	parameter int count = 8,
	parameter int width = 8
);
	localparam int addr_bits = (width > 1) ? $clog2(width) : 1;

	// One-hot buffer select, zero when idle
	logic [count-1:0]     we;
	logic [addr_bits-1:0] waddr;
	pixel_t               wdata;
	// Set once a buffer holds a complete line
	logic [count-1:0]     filled;

	modport writer (output we, waddr, wdata, filled);
	modport buffer (input we, waddr, wdata);
	// Reader only needs the fill state
	modport status (input filled);
endinterface

//////////////////////////////
// Read side of the ring
//////////////////////////////

interface line_read_if import video_pkg::*; #(
	parameter int count = 8,
	parameter int width = 8
);
	localparam int addr_bits = (width > 1) ? $clog2(width) : 1;

	// Same pixel index goes to every buffer
	logic [addr_bits-1:0] raddr;
	// One registered answer per buffer
	pixel_t               rdata [count];

	modport reader (output raddr, input rdata);
	modport buffer (input raddr, output rdata);
endinterface

`default_nettype wire

/* common/scan_timing_pkg.sv */
`default_nettype none

// Raster timing descriptions, horizontal or vertical
package scan_timing_pkg;

	// One axis of a raster, in pixels or lines
	typedef struct packed {
		logic [11:0] active;
		logic [11:0] front_porch;
		logic [11:0] sync_width;
		logic [11:0] back_porch;
	} scan_timing_t;

	// Output raster, 24 pixels by 16 lines in total
	localparam scan_timing_t out_h_timing = '{12'd16, 12'd2, 12'd3, 12'd3};
	localparam scan_timing_t out_v_timing = '{12'd12, 12'd1, 12'd2, 12'd1};

	// Source frame size
	localparam int src_width_default  = 8;
	localparam int src_height_default = 6;

	// Full period of one axis
	function automatic logic [11:0] scan_total(input scan_timing_t t);
		return t.active + t.front_porch + t.sync_width + t.back_porch;
	endfunction

	// First count of the sync pulse
	function automatic logic [11:0] sync_start(input scan_timing_t t);
		return t.active + t.front_porch;
	endfunction

endpackage

`default_nettype wire

/* common/video_pkg.sv */
`default_nettype none

// Pixel format shared across the video path
package video_pkg;

	// Bits per colour component
	localparam int component_depth = 4;

	//////////////////////////////
	// Pixel
	//////////////////////////////

	// One RGB pixel, 12 bits packed
	// Red sits in the top bits, blue in the bottom
	typedef struct packed {
		logic [component_depth-1:0] red;
		logic [component_depth-1:0] green;
		logic [component_depth-1:0] blue;
	} pixel_t;

	// Blank colour for borders and empty lines
	localparam pixel_t pixel_black = '0;

	// Whole pixel width
	localparam int pixel_bits = $bits(pixel_t);

endpackage

`default_nettype wire

/* filelist.f */
common/video_pkg.sv
common/scan_timing_pkg.sv
common/line_bus_if.sv
upscaler/line_writer.sv
upscaler/line_buffer.sv
upscaler/line_reader.sv
upscaler/upscaler.sv
logic/vga_sync_gen.sv
logic/video_scaler_top.sv
verification/video_scaler_tb.sv

/* logic/vga_sync_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_sync_gen import scan_timing_pkg::*; #(
	parameter scan_timing_t h_timing = out_h_timing,
	parameter scan_timing_t v_timing = out_v_timing
) (
	input wire pixel_clk,
	input wire reset,
	output logic [11:0] x,
	output logic [11:0] y,
	output logic active,
	output logic hsync,
	output logic vsync
);
	localparam logic [11:0] h_total = scan_total(h_timing);
	localparam logic [11:0] v_total = scan_total(v_timing);
	localparam logic [11:0] h_sync_lo = sync_start(h_timing);
	localparam logic [11:0] v_sync_lo = sync_start(v_timing);
	localparam logic [11:0] h_sync_hi = h_sync_lo + h_timing.sync_width;
	localparam logic [11:0] v_sync_hi = v_sync_lo + v_timing.sync_width;

	//////////////////////////////
	// Pixel and line counters
	//////////////////////////////

	always_ff @(posedge pixel_clk) begin
		if (reset) begin
			x <= '0;
			y <= '0;
		end else if (x == h_total - 12'd1) begin
			// End of line, step the line counter
			x <= '0;
			if (y == v_total - 12'd1)
				y <= '0;
			else
				y <= y + 12'd1;
		end else begin
			x <= x + 12'd1;
		end
	end

	// Visible area is the top left corner
	assign active = (x < h_timing.active) && (y < v_timing.active);

	// Sync pulses sit between the porches
	assign hsync = (x >= h_sync_lo) && (x < h_sync_hi);
	assign vsync = (y >= v_sync_lo) && (y < v_sync_hi);

	// Line count wraps before the vertical total
	a_y_range: assert property (@(posedge pixel_clk) disable iff (reset) y < v_total);

endmodule

`default_nettype wire

/* logic/video_scaler_top.sv */
`timescale 1ns/1ps
`default_nettype none

module video_scaler_top import video_pkg::*, scan_timing_pkg::*; #(
	parameter int line_buffer_count = 8,
	parameter int src_width = src_width_default,
	parameter int src_height = src_height_default,
	parameter scan_timing_t h_timing = out_h_timing,
	parameter scan_timing_t v_timing = out_v_timing,
	parameter int delta_precision = 12
) (
	input wire pixel_clk,
	input wire reset,
	// Source side
	input wire src_valid,
	input wire [component_depth-1:0] src_red,
	input wire [component_depth-1:0] src_green,
	input wire [component_depth-1:0] src_blue,
	input wire src_hsync,
	input wire src_vsync,
	// Scaled VGA side
	output logic [component_depth-1:0] vid_red,
	output logic [component_depth-1:0] vid_green,
	output logic [component_depth-1:0] vid_blue,
	output logic vid_hsync,
	output logic vid_vsync,
	output logic vid_hblank,
	output logic vid_vblank
);
	pixel_t      src_pixel;
	pixel_t      vid_pixel;
	logic [11:0] pos_x;
	logic [11:0] pos_y;
	logic        pos_active;
	logic        gen_hsync;
	logic        gen_vsync;

	// Plain colour ports to and from the packed pixel
	assign src_pixel = '{red: src_red, green: src_green, blue: src_blue};
	assign vid_red = vid_pixel.red;
	assign vid_green = vid_pixel.green;
	assign vid_blue = vid_pixel.blue;

	// Free running output raster
	vga_sync_gen #(.h_timing(h_timing), .v_timing(v_timing)) sync_gen_i (
		.pixel_clk(pixel_clk), .reset(reset), .x(pos_x), .y(pos_y),
		.active(pos_active), .hsync(gen_hsync), .vsync(gen_vsync)
	);

	upscaler #(
		.line_buffer_count(line_buffer_count), .src_width(src_width),
		.src_height(src_height), .h_timing(h_timing), .v_timing(v_timing),
		.delta_precision(delta_precision)
	) upscaler_i (
		.pixel_clk(pixel_clk), .reset(reset), .src_valid(src_valid),
		.src_pixel(src_pixel), .src_hsync(src_hsync), .src_vsync(src_vsync),
		.x(pos_x), .y(pos_y), .active(pos_active), .hsync_in(gen_hsync),
		.vsync_in(gen_vsync), .pixel_out(vid_pixel), .hsync(vid_hsync),
		.vsync(vid_vsync), .hblank(vid_hblank), .vblank(vid_vblank)
	);

endmodule

`default_nettype wire

/* upscaler/line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module line_buffer import video_pkg::*; #(
	parameter int src_width = 8,
	parameter int index = 0
) (
	input wire pixel_clk,
	line_write_if.buffer wr,
	line_read_if.buffer rd
);
	// One source line of pixels
	pixel_t mem [src_width];
	pixel_t rdata_q;

	//////////////////////////////
	// Storage
	//////////////////////////////

	always_ff @(posedge pixel_clk) begin
		// Only this buffer's select bit writes
		if (wr.we[index])
			mem[wr.waddr] <= wr.wdata;
	end

	// Registered read, data one cycle after raddr
	always_ff @(posedge pixel_clk) begin
		rdata_q <= mem[rd.raddr];
	end

	// Own slot of the shared read array
	assign rd.rdata[index] = rdata_q;

	// Write address stays inside the line
	a_waddr_range: assert property (@(posedge pixel_clk)
		wr.we[index] |-> (int'(wr.waddr) < src_width));

endmodule

`default_nettype wire

/* upscaler/line_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module line_reader import video_pkg::*, scan_timing_pkg::*; #(
	parameter int line_buffer_count = 8,
	parameter int src_width = src_width_default,
	parameter int src_height = src_height_default,
	parameter scan_timing_t h_timing = out_h_timing,
	parameter scan_timing_t v_timing = out_v_timing,
	parameter int delta_precision = 12
) (
	input wire pixel_clk,
	input wire reset,
	input wire [11:0] x,
	input wire [11:0] y,
	input wire active,
	input wire hsync_in,
	input wire vsync_in,
	line_write_if.status status,
	line_read_if.reader rd,
	output pixel_t pixel_out,
	output logic hsync,
	output logic vsync,
	output logic hblank,
	output logic vblank
);
	localparam int addr_bits = (src_width > 1) ? $clog2(src_width) : 1;
	localparam int idx_bits = (line_buffer_count > 1) ? $clog2(line_buffer_count) : 1;
	// Fixed-point steps in source pixels per output pixel
	localparam int h_step = (src_width << delta_precision) / int'(h_timing.active);
	localparam int v_step = (src_height << delta_precision) / int'(v_timing.active);

	logic [43:0]          h_prod;
	logic [43:0]          v_prod;
	logic [11:0]          src_line;
	logic [idx_bits-1:0]  buf_idx;
	// Stage 1 state
	logic [idx_bits-1:0]  buf_idx_q;
	logic                 filled_q;
	logic                 active_q;
	logic                 hsync_q;
	logic                 vsync_q;
	logic                 hblank_q;
	logic                 vblank_q;

	//////////////////////////////
	// Stage 1 source position
	//////////////////////////////

	assign h_prod = 44'(x) * 44'(h_step);
	assign v_prod = 44'(y) * 44'(v_step);
	assign src_line = v_prod[delta_precision +: 12];
	assign buf_idx = idx_bits'(src_line % 12'(line_buffer_count));
	// Park on pixel 0 outside the active area
	assign rd.raddr = active ? h_prod[delta_precision +: addr_bits] : '0;

	always_ff @(posedge pixel_clk) begin
		if (reset) begin
			buf_idx_q <= '0;
			filled_q <= 1'b0;
			active_q <= 1'b0;
			hsync_q <= 1'b0;
			vsync_q <= 1'b0;
			hblank_q <= 1'b1;
			vblank_q <= 1'b1;
		end else begin
			buf_idx_q <= buf_idx;
			filled_q <= status.filled[buf_idx];
			active_q <= active;
			hsync_q <= hsync_in;
			vsync_q <= vsync_in;
			hblank_q <= (x >= h_timing.active);
			vblank_q <= (y >= v_timing.active);
		end
	end

	// Stage 2 picks the answering buffer
	always_ff @(posedge pixel_clk) begin
		if (reset) begin
			pixel_out <= pixel_black;
			hsync <= 1'b0;
			vsync <= 1'b0;
			hblank <= 1'b1;
			vblank <= 1'b1;
		end else begin
			// Black for borders and lines not yet loaded
			pixel_out <= (active_q && filled_q) ? rd.rdata[buf_idx_q] : pixel_black;
			hsync <= hsync_q;
			vsync <= vsync_q;
			hblank <= hblank_q;
			vblank <= vblank_q;
		end
	end

	// Step math keeps fetches inside the line
	a_raddr_range: assert property (@(posedge pixel_clk) disable iff (reset)
		active |-> (int'(h_prod[delta_precision +: 12]) < src_width));

endmodule

`default_nettype wire

/* upscaler/line_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module line_writer import video_pkg::*; #(
	parameter int line_buffer_count = 8,
	parameter int src_width = 8
) (
	input wire pixel_clk,
	input wire reset,
	input wire src_valid,
	input wire pixel_t src_pixel,
	input wire src_hsync,
	input wire src_vsync,
	line_write_if.writer wr
);
	localparam int addr_bits = (src_width > 1) ? $clog2(src_width) : 1;
	localparam int x_bits = $clog2(src_width + 1);
	localparam int idx_bits = (line_buffer_count > 1) ? $clog2(line_buffer_count) : 1;

	logic [x_bits-1:0]            x_q;
	logic [idx_bits-1:0]          line_idx_q;
	logic [line_buffer_count-1:0] filled_q;
	logic                         in_line;

	// Pixels past the line width are dropped
	assign in_line = (x_q < x_bits'(src_width));

	// Write goes straight through in the strobe cycle
	assign wr.we = (src_valid && in_line) ? (line_buffer_count'(1) << line_idx_q) : '0;
	assign wr.waddr = addr_bits'(x_q);
	assign wr.wdata = src_pixel;
	assign wr.filled = filled_q;

	//////////////////////////////
	// Position and fill tracking
	//////////////////////////////

	always_ff @(posedge pixel_clk) begin
		if (reset) begin
			x_q <= '0;
			line_idx_q <= '0;
			filled_q <= '0;
		end else if (src_vsync) begin
			// New frame, ring starts over empty
			x_q <= '0;
			line_idx_q <= '0;
			filled_q <= '0;
		end else if (src_hsync) begin
			// Close current line, move to next buffer
			x_q <= '0;
			filled_q[line_idx_q] <= 1'b1;
			if (line_idx_q == idx_bits'(line_buffer_count - 1))
				line_idx_q <= '0;
			else
				line_idx_q <= line_idx_q + 1'b1;
		end else if (src_valid && in_line) begin
			x_q <= x_q + 1'b1;
		end
	end

	// At most one buffer written per cycle
	a_we_onehot: assert property (@(posedge pixel_clk) disable iff (reset) $onehot0(wr.we));

endmodule

`default_nettype wire

/* upscaler/upscaler.sv */
`timescale 1ns/1ps
`default_nettype none

module upscaler import video_pkg::*, scan_timing_pkg::*; #(
	parameter int line_buffer_count = 8,
	parameter int src_width = src_width_default,
	parameter int src_height = src_height_default,
	parameter scan_timing_t h_timing = out_h_timing,
	parameter scan_timing_t v_timing = out_v_timing,
	parameter int delta_precision = 12
) (
	input wire pixel_clk,
	input wire reset,
	// Source stream
	input wire src_valid,
	input wire pixel_t src_pixel,
	input wire src_hsync,
	input wire src_vsync,
	// Output raster position
	input wire [11:0] x,
	input wire [11:0] y,
	input wire active,
	input wire hsync_in,
	input wire vsync_in,
	// Scaled output
	output pixel_t pixel_out,
	output logic hsync,
	output logic vsync,
	output logic hblank,
	output logic vblank
);
	line_write_if #(.count(line_buffer_count), .width(src_width)) wr_bus ();
	line_read_if #(.count(line_buffer_count), .width(src_width)) rd_bus ();

	// Source pixels into the ring
	line_writer #(
		.line_buffer_count(line_buffer_count),
		.src_width(src_width)
	) writer_i (
		.pixel_clk(pixel_clk),
		.reset(reset),
		.src_valid(src_valid),
		.src_pixel(src_pixel),
		.src_hsync(src_hsync),
		.src_vsync(src_vsync),
		.wr(wr_bus.writer)
	);

	//////////////////////////////
	// Buffer ring
	//////////////////////////////

	for (genvar i = 0; i < line_buffer_count; i++) begin : g_buffer
		line_buffer #(
			.src_width(src_width),
			.index(i)
		) buffer_i (
			.pixel_clk(pixel_clk),
			.wr(wr_bus.buffer),
			.rd(rd_bus.buffer)
		);
	end

	// Output pixels out of the ring
	line_reader #(
		.line_buffer_count(line_buffer_count),
		.src_width(src_width),
		.src_height(src_height),
		.h_timing(h_timing),
		.v_timing(v_timing),
		.delta_precision(delta_precision)
	) reader_i (
		.pixel_clk(pixel_clk),
		.reset(reset),
		.x(x),
		.y(y),
		.active(active),
		.hsync_in(hsync_in),
		.vsync_in(vsync_in),
		.status(wr_bus.status),
		.rd(rd_bus.reader),
		.pixel_out(pixel_out),
		.hsync(hsync),
		.vsync(vsync),
		.hblank(hblank),
		.vblank(vblank)
	);

endmodule

`default_nettype wire

/* verification/video_scaler_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module video_scaler_tb import video_pkg::*, scan_timing_pkg::*;;
	// Output raster and source geometry
	localparam int src_w = src_width_default;
	localparam int src_h = src_height_default;
	localparam int h_active = out_h_timing.active;
	localparam int v_active = out_v_timing.active;
	localparam int h_total = out_h_timing.active + out_h_timing.front_porch
		+ out_h_timing.sync_width + out_h_timing.back_porch;
	localparam int v_total = out_v_timing.active + out_v_timing.front_porch
		+ out_v_timing.sync_width + out_v_timing.back_porch;
	// Nearest neighbour steps, 12 fraction bits
	localparam int precision = 12;
	localparam int h_step = src_w * (1 << precision) / h_active;
	localparam int v_step = src_h * (1 << precision) / v_active;
	localparam int wait_limit = 4 * h_total * v_total;

	logic pixel_clk = 1'b0;
	logic reset;
	logic src_valid, src_hsync, src_vsync;
	logic [component_depth-1:0] src_red, src_green, src_blue;
	logic [component_depth-1:0] vid_red, vid_green, vid_blue;
	logic vid_hsync, vid_vsync, vid_hblank, vid_vblank;

	// Source frame model and fill state
	logic [pixel_bits-1:0] src_frame [src_h][src_w];
	logic line_loaded [src_h];
	logic [31:0] lfsr_state;
	logic check_en, checking_q, in_reset_q;
	int error_count, checked_count;
	int ax, ay, hs_len, hs_pulses, vs_len;
	logic vs_seen;

	always #10 pixel_clk = ~pixel_clk;

	video_scaler_top dut_i (
		.pixel_clk(pixel_clk), .reset(reset), .src_valid(src_valid),
		.src_red(src_red), .src_green(src_green), .src_blue(src_blue),
		.src_hsync(src_hsync), .src_vsync(src_vsync),
		.vid_red(vid_red), .vid_green(vid_green), .vid_blue(vid_blue),
		.vid_hsync(vid_hsync), .vid_vsync(vid_vsync),
		.vid_hblank(vid_hblank), .vid_vblank(vid_vblank)
	);

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			abort_run($sformatf("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp));
		end
	endtask

	// Galois LFSR, taps 32,30,26,25
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	// One LFSR step per colour bit
	task automatic next_pixel(output logic [pixel_bits-1:0] px);
		px = '0;
		for (int i = 0; i < pixel_bits; i++) begin
			px = {px[pixel_bits-2:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// Expected colour for an output position
	function automatic logic [pixel_bits-1:0] expected_pixel(input int ox, input int oy);
		int sx;
		int sy;
		if (ox >= h_active || oy >= v_active)
			return '0;
		sx = (ox * h_step) >> precision;
		sy = (oy * v_step) >> precision;
		if (!line_loaded[sy])
			return '0;
		return src_frame[sy][sx];
	endfunction

	// One source cycle, set on the falling edge
	task automatic source_cycle(input logic valid, input logic hs, input logic vs,
		input logic [pixel_bits-1:0] px);
		@(negedge pixel_clk);
		src_valid = valid;
		src_hsync = hs;
		src_vsync = vs;
		{src_red, src_green, src_blue} = px;
	endtask

	task automatic start_frame();
		source_cycle(1'b0, 1'b0, 1'b1, '0);
		for (int l = 0; l < src_h; l++)
			line_loaded[l] = 1'b0;
	endtask

	// Noisy lines add junk while idle and two pixels past the width
	task automatic load_line(input int line, input logic noisy);
		logic [pixel_bits-1:0] px;
		for (int i = 0; i < src_w; i++) begin
			if (noisy) begin
				next_pixel(px);
				source_cycle(1'b0, 1'b0, 1'b0, px);
			end
			next_pixel(px);
			src_frame[line][i] = px;
			source_cycle(1'b1, 1'b0, 1'b0, px);
		end
		if (noisy) begin
			repeat (2) begin
				next_pixel(px);
				source_cycle(1'b1, 1'b0, 1'b0, px);
			end
		end
		source_cycle(1'b0, 1'b1, 1'b0, '0);
		line_loaded[line] = 1'b1;
		source_cycle(1'b0, 1'b0, 1'b0, '0);
	endtask

	task automatic wait_for_vblank(input logic level);
		int cycles;
		cycles = 0;
		while (vid_vblank !== level) begin
			@(negedge pixel_clk);
			cycles++;
			if (cycles > wait_limit)
				abort_run("timeout while waiting for vid_vblank to change");
		end
	endtask

	// Compare one whole output frame against the model
	task automatic check_frame();
		wait_for_vblank(1'b1);
		checked_count = 0;
		check_en = 1'b1;
		wait_for_vblank(1'b0);
		wait_for_vblank(1'b1);
		check_en = 1'b0;
		check_value("active pixels per frame", checked_count, h_active * v_active);
	endtask

	//////////////////////////////
	// Checker
	//////////////////////////////

	// Control flags move on the rising edge, sampling on the falling one
	always @(posedge pixel_clk) begin
		checking_q <= check_en;
		in_reset_q <= reset;
	end

	always @(negedge pixel_clk) begin
		if (!in_reset_q) begin
			if (vid_hblank || vid_vblank)
				check_value("vid_pixel in blanking", {vid_red, vid_green, vid_blue}, '0);
			// Position from blanking levels
			if (vid_vblank) begin
				ax = 0;
				ay = 0;
			end else if (!vid_hblank) begin
				if (checking_q) begin
					check_value("vid_pixel", {vid_red, vid_green, vid_blue},
						expected_pixel(ax, ay));
					checked_count++;
				end
				ax++;
			end else if (ax != 0) begin
				ax = 0;
				ay++;
			end
			// Sync pulse widths and counts
			if (vid_hsync) begin
				hs_len++;
			end else if (hs_len != 0) begin
				check_value("vid_hsync width", hs_len, out_h_timing.sync_width);
				hs_len = 0;
				hs_pulses++;
			end
			if (vid_vsync) begin
				if (vs_len == 0) begin
					if (vs_seen)
						check_value("vid_hsync pulses per frame", hs_pulses, v_total);
					vs_seen = 1'b1;
					hs_pulses = 0;
				end
				vs_len++;
			end else if (vs_len != 0) begin
				check_value("vid_vsync width", vs_len, out_v_timing.sync_width * h_total);
				vs_len = 0;
			end
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial begin
		reset = 1'b1;
		src_valid = 1'b0;
		src_hsync = 1'b0;
		src_vsync = 1'b0;
		{src_red, src_green, src_blue} = '0;
		lfsr_state = 32'h998b425f;
		check_en = 1'b0;
		error_count = 0;
		checked_count = 0;
		{ax, ay, hs_len, hs_pulses, vs_len} = '0;
		vs_seen = 1'b0;
		for (int l = 0; l < src_h; l++)
			line_loaded[l] = 1'b0;
		repeat (5) @(negedge pixel_clk);
		// Reset levels on the outputs
		check_value("vid_pixel", {vid_red, vid_green, vid_blue}, '0);
		check_value("vid_hblank", vid_hblank, 1'b1);
		check_value("vid_vblank", vid_vblank, 1'b1);
		check_value("vid_hsync", vid_hsync, 1'b0);
		check_value("vid_vsync", vid_vsync, 1'b0);
		reset = 1'b0;
		// Nothing loaded yet, all black
		check_frame();
		// Full source frame
		start_frame();
		for (int l = 0; l < src_h; l++)
			load_line(l, 1'b0);
		check_frame();
		// Three lines only, rest black
		start_frame();
		for (int l = 0; l < 3; l++)
			load_line(l, 1'b0);
		check_frame();
		// Junk while idle and past the line end
		start_frame();
		for (int l = 0; l < src_h; l++)
			load_line(l, 1'b1);
		check_frame();
		if (error_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire
